/* logic/rv_pkg.sv */
package rv_pkg;

    // ==============================
    // Widths and sizes
    // ==============================
    typedef logic [31:0] word_t;    // Data and addresses
    typedef logic [4:0]  reg_idx_t; // Register index

    localparam int    IMEM_WORDS = 64;
    localparam int    IMEM_AW    = $clog2(IMEM_WORDS); // Word index bits
    localparam int    DMEM_BYTES = 128;
    localparam int    DMEM_AW    = $clog2(DMEM_BYTES); // Byte index bits
    localparam word_t RESET_PC   = 32'h0000_0000;

    // ==============================
    // RV32I opcodes
    // ==============================
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011; // Only ebreak is handled

    // ==============================
    // Control encodings
    // ==============================
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B  // lui passes the immediate straight through
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     a_is_pc;   // ALU A from PC instead of rs1
        logic     b_is_imm;  // ALU B from immediate instead of rs2
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        logic     branch;    // Conditional branch
        logic     jump;      // jal / jalr
        imm_fmt_e imm_fmt;
        wb_src_e  wb_src;
        logic     halt;      // ebreak seen
    } ctrl_t;

    // Bubble: nothing written, no redirect
    localparam ctrl_t CTRL_NOP = '{
        alu_op: ALU_ADD, a_is_pc: 1'b0, b_is_imm: 1'b0, reg_write: 1'b0,
        mem_write: 1'b0, mem_read: 1'b0, branch: 1'b0, jump: 1'b0,
        imm_fmt: IMM_I, wb_src: WB_ALU, halt: 1'b0
    };

    // Debug register read port, four-phase
    typedef struct packed {
        logic     req;
        reg_idx_t addr;
    } dbg_req_t;

    typedef struct packed {
        logic  ack;
        word_t data;
    } dbg_rsp_t;

endpackage

/* logic/instruction_memory.sv */
`timescale 1ns/1ps

module instruction_memory import rv_pkg::*; (
    input  word_t pc,
    output word_t instr
);

    word_t rom [IMEM_WORDS];

    // Unused words read as zero, decoded as a bubble
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++)
            rom[i] = '0;
        $readmemh("sim/program.hex", rom);
    end

    assign instr = rom[pc[IMEM_AW+1:2]]; // Word index, byte offset dropped

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_ebreak;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // imm=1, rs1/funct3/rd all zero
    assign is_ebreak = (instr[31:20] == 12'h001) && (instr[19:7] == '0);

    // funct3 to ALU op, alt picks sub / sra
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl = CTRL_NOP;  // Unknown opcode stays a bubble
        case (opcode)
            OP_REG: begin
                ctrl.alu_op    = decode_alu(funct3, funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                // Only srai uses funct7, addi has no subi
                ctrl.alu_op    = decode_alu(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.b_is_imm  = 1'b1;
                ctrl.imm_fmt   = IMM_U;
                ctrl.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.imm_fmt   = IMM_U;
                ctrl.reg_write = 1'b1;
            end
            OP_JAL: begin
                ctrl.a_is_pc   = 1'b1;       // Target = PC + imm
                ctrl.b_is_imm  = 1'b1;
                ctrl.imm_fmt   = IMM_J;
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_PC4;
            end
            OP_JALR: begin
                ctrl.b_is_imm  = 1'b1;       // Target = rs1 + imm
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_PC4;
            end
            OP_BRANCH: begin
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.imm_fmt   = IMM_B;
                ctrl.branch    = 1'b1;
            end
            OP_LOAD: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_MEM;
            end
            OP_STORE: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.imm_fmt   = IMM_S;
                ctrl.mem_write = 1'b1;
            end
            OP_SYSTEM: ctrl.halt = is_ebreak;  // ecall and CSRs ignored
            default: ;
        endcase
    end

endmodule

/* logic/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  word_t    instr,
    input  imm_fmt_e fmt,
    output word_t    imm
);

    logic sign;

    assign sign = instr[31];  // Sign bit in every format

    always_comb begin
        case (fmt)
            IMM_S:   imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offset, bit 0 implied zero
            IMM_B:   imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};  // Upper 20 bits
            IMM_J:   imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{sign}}, instr[31:20]}; // I format
        endcase
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wdata,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  dbg_req_t dbg,
    output dbg_rsp_t dbg_rsp
);

    typedef enum logic [1:0] {DBG_IDLE, DBG_ACK, DBG_RELEASE} dbg_state_e;

    word_t      regs [32];
    dbg_state_e dbg_state;
    word_t      dbg_data;  // Value held while ack is high

    // ==============================
    // Core ports
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;  // x0 never written
        end
    end

    assign rs1_data = regs[rs1];  // Asynchronous read
    assign rs2_data = regs[rs2];

    // ==============================
    // Debug handshake
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbg_state <= DBG_IDLE;
        end else begin
            case (dbg_state)
                DBG_IDLE:    if (dbg.req) dbg_state <= DBG_ACK;
                DBG_ACK:     if (!dbg.req) dbg_state <= DBG_RELEASE; // ack drops
                DBG_RELEASE: dbg_state <= DBG_IDLE;  // One turnaround cycle
                default:     dbg_state <= DBG_IDLE;
            endcase
        end
    end

    // Capture on the edge that raises ack
    always_ff @(posedge clk) begin
        if (dbg_state == DBG_IDLE && dbg.req)
            dbg_data <= regs[dbg.addr];
    end

    assign dbg_rsp = '{ack: (dbg_state == DBG_ACK), data: dbg_data};

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only low five bits shift

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt); // Sign fill
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;  // lui
            default:    result = '0;
        endcase
    end

endmodule

/* logic/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import rv_pkg::*; (
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    input  logic [2:0] funct3,
    input  logic       branch,
    input  logic       jump,
    output logic       taken
);

    logic cond;

    // Branch condition per funct3
    always_comb begin
        case (funct3)
            3'b000:  cond = (rs1_data == rs2_data);                  // beq
            3'b001:  cond = (rs1_data != rs2_data);                  // bne
            3'b100:  cond = ($signed(rs1_data) <  $signed(rs2_data)); // blt
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  cond = (rs1_data <  rs2_data);                  // bltu
            3'b111:  cond = (rs1_data >= rs2_data);                  // bgeu
            default: cond = 1'b0;  // Reserved encodings
        endcase
    end

    assign taken = jump || (branch && cond);

endmodule

/* logic/data_memory.sv */
`timescale 1ns/1ps

module data_memory import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  word_t      addr,
    input  word_t      wdata,
    input  logic [2:0] funct3,  // Size in [1:0], unsigned in [2]
    input  logic       we,
    input  logic       re,
    output word_t      rdata
);

    logic [7:0]         mem [DMEM_BYTES];
    logic [DMEM_AW-1:0] a0, a1, a2, a3;  // Byte lanes, wrap in array
    logic [7:0]         b0, b1, b2, b3;

    assign a0 = addr[DMEM_AW-1:0];
    assign a1 = a0 + DMEM_AW'(1);
    assign a2 = a0 + DMEM_AW'(2);
    assign a3 = a0 + DMEM_AW'(3);

    // ==============================
    // Stores, little-endian
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_BYTES; i++)
                mem[i] <= '0;
        end else if (we) begin
            mem[a0] <= wdata[7:0];
            if (funct3[1:0] != 2'b00)
                mem[a1] <= wdata[15:8];   // sh, sw
            if (funct3[1:0] == 2'b10) begin
                mem[a2] <= wdata[23:16];  // sw only
                mem[a3] <= wdata[31:24];
            end
        end
    end

    // ==============================
    // Loads
    // ==============================
    assign b0 = mem[a0];
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    always_comb begin
        rdata = '0;  // Quiet bus when not loading
        if (re) begin
            case (funct3)
                3'b000:  rdata = {{24{b0[7]}}, b0};      // lb
                3'b001:  rdata = {{16{b1[7]}}, b1, b0};  // lh
                3'b010:  rdata = {b3, b2, b1, b0};       // lw
                3'b100:  rdata = {24'b0, b0};            // lbu
                3'b101:  rdata = {16'b0, b1, b0};        // lhu
                default: rdata = '0;
            endcase
        end
    end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  dbg_req_t dbg,      // Debug read request
    output dbg_rsp_t dbg_rsp,  // Debug read response
    output logic     halted    // High after ebreak until reset
);

    word_t    pc, pc_plus4, next_pc, jump_target;
    word_t    instr, imm;
    word_t    rs1_data, rs2_data;
    word_t    alu_a, alu_b, alu_result;
    word_t    mem_rdata, wb_data;
    ctrl_t    ctrl;
    logic     taken;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t rs1, rs2, rd;

    // Instruction fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // ==============================
    // PC and halt
    // ==============================
    assign pc_plus4 = pc + 32'd4;

    // jalr drops bit 0 of the target
    assign jump_target = (opcode == OP_JALR) ? {alu_result[31:1], 1'b0} : alu_result;

    // Hold on ebreak so it stays presented
    always_comb begin
        if (halted || ctrl.halt)
            next_pc = pc;
        else if (taken)
            next_pc = jump_target;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= RESET_PC;
        else
            pc <= next_pc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            halted <= 1'b0;
        else if (ctrl.halt)
            halted <= 1'b1;  // Sticky until reset
    end

    // ==============================
    // Datapath
    // ==============================
    instruction_memory u_imem (.pc(pc), .instr(instr));

    control_unit u_ctrl (.instr(instr), .ctrl(ctrl));

    imm_gen u_imm (.instr(instr), .fmt(ctrl.imm_fmt), .imm(imm));

    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (ctrl.reg_write),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg      (dbg),
        .dbg_rsp  (dbg_rsp)
    );

    assign alu_a = ctrl.a_is_pc  ? pc  : rs1_data; // PC for auipc, jal, branches
    assign alu_b = ctrl.b_is_imm ? imm : rs2_data;

    alu u_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result));

    branch_unit u_branch (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .funct3   (funct3),
        .branch   (ctrl.branch),
        .jump     (ctrl.jump),
        .taken    (taken)
    );

    data_memory u_dmem (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr   (alu_result), // Effective address from ALU
        .wdata  (rs2_data),
        .funct3 (funct3),     // Access size and extension
        .we     (ctrl.mem_write),
        .re     (ctrl.mem_read),
        .rdata  (mem_rdata)
    );

    // Write-back select
    always_comb begin
        case (ctrl.wb_src)
            WB_MEM:  wb_data = mem_rdata;
            WB_PC4:  wb_data = pc_plus4;  // Link address
            default: wb_data = alu_result;
        endcase
    end

endmodule

/* sim/rv_core_assertions.sv */
`timescale 1ns/1ps

module rv_core_assertions import rv_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input dbg_req_t dbg,      // Same nets as the register file debug port
    input dbg_rsp_t dbg_rsp,
    input logic     halted
);

    // ==============================
    // Debug handshake
    // ==============================
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(dbg_rsp.ack) |-> $past(dbg.req)  // Request seen one edge earlier
    ) else $error("debug ack rose without a request");

    a_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dbg_rsp.ack && $past(dbg_rsp.ack)) |-> $stable(dbg_rsp.data)
    ) else $error("debug data changed while ack was high");

    // ==============================
    // Halt
    // ==============================
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted  // Only reset clears it
    ) else $error("halted dropped before reset");

endmodule

bind rv_core rv_core_assertions u_rv_core_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .dbg     (dbg),
    .dbg_rsp (dbg_rsp),
    .halted  (halted)
);

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

    localparam int HALT_TIMEOUT = 200;  // Cycles for the whole program
    localparam int ACK_TIMEOUT  = 20;   // Cycles per handshake phase

    logic     clk;
    logic     rst_n;
    dbg_req_t dbg;
    dbg_rsp_t dbg_rsp;
    logic     halted;

    int     checks;
    int     errors;
    integer seed = 32'h5376_c839;  // Random debug read order

    rv_core u_rv_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .dbg     (dbg),
        .dbg_rsp (dbg_rsp),
        .halted  (halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // ==============================
    // Expected state after ebreak
    // ==============================
    // Worked out by hand from the listing in program.hex
    function automatic word_t expected_reg(input reg_idx_t idx);
        case (idx)
            5'd1:    return 32'h0000_0005;
            5'd2:    return 32'hFFFF_FFFD;
            5'd3:    return 32'h8000_80F0;  // lui + addi
            5'd4:    return 32'h0000_0002;
            5'd5:    return 32'h8000_80F0;  // lw
            5'd6:    return 32'h0000_0008;
            5'd7:    return 32'h0000_00A0;
            5'd8:    return 32'hFFFF_FFFF;  // Sign fill
            5'd9:    return 32'h07FF_FFFF;
            5'd10:   return 32'h0000_0001;
            5'd11:   return 32'h0000_0000;
            5'd12:   return 32'hFFFF_FFF8;
            5'd13:   return 32'hFFFF_FFFD;
            5'd14:   return 32'h0000_0005;
            5'd15:   return 32'hFFFF_FFF0;  // lb
            5'd16:   return 32'h0000_00F0;  // lbu
            5'd17:   return 32'hFFFF_80F0;  // lh
            5'd18:   return 32'h0000_80F0;  // lhu
            5'd19:   return 32'h0000_0007;  // Both skipped writes lost
            5'd20:   return 32'h0000_000B;
            5'd21:   return 32'h0000_0068;  // jal link
            5'd22:   return 32'h0000_007C;
            5'd23:   return 32'h0000_0074;  // jalr link
            default: return 32'h0;  // x0, skipped x24, unused registers
        endcase
    endfunction

    // ==============================
    // Debug port access
    // ==============================
    // Starts and ends on a falling edge
    task automatic dbg_read(input reg_idx_t idx, output word_t data);
        int wait_cycles;
        data = '0;
        dbg.addr = idx;
        dbg.req  = 1'b1;  // Phase 1
        wait_cycles = 0;
        while (!dbg_rsp.ack && wait_cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!dbg_rsp.ack) begin
            $display("Debug read of x%0d timed out waiting for ack to rise", idx);
            errors++;
        end else begin
            data = dbg_rsp.data;  // Phase 2
        end
        dbg.req = 1'b0;   // Phase 3
        wait_cycles = 0;
        while (dbg_rsp.ack && wait_cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (dbg_rsp.ack) begin
            $display("Debug read of x%0d timed out waiting for ack to fall", idx);
            errors++;
        end
    endtask

    task automatic check_reg(input reg_idx_t idx, input word_t expected);
        word_t got;
        dbg_read(idx, got);
        checks++;
        if (got !== expected) begin
            $display("[FAIL] %0t ns: x%0d = 0x%08h, expected 0x%08h",
                     $time, idx, got, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d error(s)", name, errors - errors_before);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset();
        int start_errors;
        start_errors = errors;
        rst_n = 1'b0;
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (halted !== 1'b0 || dbg_rsp.ack !== 1'b0) begin
                $display("[FAIL] %0t ns: halted=%b ack=%b in reset",
                         $time, halted, dbg_rsp.ack);
                errors++;
            end
        end
        rst_n = 1'b1;
        checks++;
        if (halted !== 1'b0 || dbg_rsp.ack !== 1'b0) begin
            $display("[FAIL] %0t ns: halted=%b ack=%b after reset",
                     $time, halted, dbg_rsp.ack);
            errors++;
        end
        check_reg(5'd5, 32'h0);  // lw into x5 is 20 instructions away
        report_test("reset", start_errors);
    endtask

    task automatic test_completion();
        int       start_errors;
        int       wait_cycles;
        reg_idx_t probe [4] = '{5'd5, 5'd19, 5'd21, 5'd23};
        word_t    first [4];
        word_t    again;
        start_errors = errors;
        wait_cycles = 0;
        while (!halted && wait_cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        checks++;
        if (!halted) begin
            $display("Core did not halt within %0d cycles", HALT_TIMEOUT);
            errors++;
        end
        for (int i = 0; i < 4; i++)
            dbg_read(probe[i], first[i]);
        repeat (10) begin
            @(negedge clk);
            checks++;
            if (!halted) begin
                $display("[FAIL] %0t ns: halted dropped after ebreak", $time);
                errors++;
            end
        end
        for (int i = 0; i < 4; i++) begin
            dbg_read(probe[i], again);
            checks++;
            if (again !== first[i]) begin
                $display("[FAIL] %0t ns: x%0d moved from 0x%08h to 0x%08h while halted",
                         $time, probe[i], first[i], again);
                errors++;
            end
        end
        report_test("completion", start_errors);
    endtask

    task automatic test_arith();
        int start_errors;
        start_errors = errors;
        for (int i = 1; i <= 14; i++) begin
            if (i != 5)  // x5 holds the lw result
                check_reg(reg_idx_t'(i), expected_reg(reg_idx_t'(i)));
        end
        report_test("arith", start_errors);
    endtask

    task automatic test_memory();
        int start_errors;
        start_errors = errors;
        for (int i = 15; i <= 18; i++)
            check_reg(reg_idx_t'(i), expected_reg(reg_idx_t'(i)));
        check_reg(5'd5, 32'h8000_80F0);
        report_test("memory", start_errors);
    endtask

    task automatic test_control();
        int start_errors;
        start_errors = errors;
        for (int i = 19; i <= 24; i++)
            check_reg(reg_idx_t'(i), expected_reg(reg_idx_t'(i)));
        report_test("control", start_errors);
    endtask

    task automatic test_debug();
        int       start_errors;
        reg_idx_t idx;
        start_errors = errors;
        check_reg(5'd0, 32'h0);
        check_reg(5'd3, 32'h8000_80F0);  // Back to back reads of other registers
        check_reg(5'd0, 32'h0);
        check_reg(5'd2, 32'hFFFF_FFFD);
        repeat (12) begin
            idx = reg_idx_t'($random(seed));
            check_reg(idx, expected_reg(idx));
        end
        report_test("debug", start_errors);
    endtask

    initial begin
        rst_n  = 1'b0;
        dbg    = '0;
        checks = 0;
        errors = 0;
        test_reset();
        test_completion();
        test_arith();
        test_memory();
        test_control();
        test_debug();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* sim/program.hex */
// One instruction word per line, in address order from 0x00
// Comment gives byte address, assembly and the expected result
00500093 // 0x00 addi x1, x0, 5        x1 = 0x00000005
FFD00113 // 0x04 addi x2, x0, -3       x2 = 0xFFFFFFFD
800081B7 // 0x08 lui  x3, 0x80008      x3 = 0x80008000
0F018193 // 0x0C addi x3, x3, 0xF0     x3 = 0x800080F0
00208233 // 0x10 add  x4, x1, x2       x4 = 0x00000002
40208333 // 0x14 sub  x6, x1, x2       x6 = 0x00000008
001093B3 // 0x18 sll  x7, x1, x1       x7 = 0x000000A0
40115433 // 0x1C sra  x8, x2, x1       x8 = 0xFFFFFFFF
001154B3 // 0x20 srl  x9, x2, x1       x9 = 0x07FFFFFF
00112533 // 0x24 slt  x10, x2, x1      x10 = 0x00000001
001135B3 // 0x28 sltu x11, x2, x1      x11 = 0x00000000
0020C633 // 0x2C xor  x12, x1, x2      x12 = 0xFFFFFFF8
0020E6B3 // 0x30 or   x13, x1, x2      x13 = 0xFFFFFFFD
0020F733 // 0x34 and  x14, x1, x2      x14 = 0x00000005
00302823 // 0x38 sw   x3, 16(x0)       mem[16..19] = F0 80 00 80
01000783 // 0x3C lb   x15, 16(x0)      x15 = 0xFFFFFFF0
01004803 // 0x40 lbu  x16, 16(x0)      x16 = 0x000000F0
01001883 // 0x44 lh   x17, 16(x0)      x17 = 0xFFFF80F0
01005903 // 0x48 lhu  x18, 16(x0)      x18 = 0x000080F0
01002283 // 0x4C lw   x5, 16(x0)       x5 = 0x800080F0
00700993 // 0x50 addi x19, x0, 7       x19 = 0x00000007
00108463 // 0x54 beq  x1, x1, +8       taken to 0x5C
06300993 // 0x58 addi x19, x0, 99      skipped
00109463 // 0x5C bne  x1, x1, +8       not taken
00B00A13 // 0x60 addi x20, x0, 11      x20 = 0x0000000B
00800AEF // 0x64 jal  x21, +8          x21 = 0x00000068, to 0x6C
03700993 // 0x68 addi x19, x0, 55      skipped
07C00B13 // 0x6C addi x22, x0, 0x7C    x22 = 0x0000007C
001B0BE7 // 0x70 jalr x23, 1(x22)      x23 = 0x00000074, to 0x7C
04200C13 // 0x74 addi x24, x0, 66      skipped
04D00C13 // 0x78 addi x24, x0, 77      skipped
00100073 // 0x7C ebreak

/* rv_core.f */
logic/rv_pkg.sv
logic/instruction_memory.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/register_file.sv
logic/alu.sv
logic/branch_unit.sv
logic/data_memory.sv
logic/rv_core.sv
sim/rv_core_assertions.sv
sim/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator, from the project root
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1
[ -f sim.log ] || { echo "Build failed, no simulation log"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "test passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation clean"
exit 0
